//--- symb_rate_div.f
+incdir+.
symb_rate_div_pkg.sv
symb_rate_div_csr.sv
symb_rate_div_feed.sv
symb_rate_div_interp_stage.sv
symb_rate_div_drain.sv
symb_rate_div_top.sv
symb_rate_div_tb.sv

//--- symb_rate_div_tb.sv
////////////////////////////////////////////////////////////////////////////
// Table-driven testbench, register checks and model-checked frames
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

module symb_rate_div_tb;

    typedef symb_rate_div_pkg::avmm_resp_e resp_e;

    // Columns are kind, byte address, write, data, response, read data, rate, length, mid write
    typedef struct packed {
        logic                         frame;
        logic [`SRD_ADDR_W-1:0]       addr;
        logic                         wr;
        logic [`SRD_DATA_W-1:0]       data;
        resp_e                        resp;
        logic [`SRD_DATA_W-1:0]       rdata;
        symb_rate_div_pkg::rate_sel_e rate;
        logic [7:0]                   len;
        logic                         mid_wr;
    } entry_t;

    localparam resp_e OK  = symb_rate_div_pkg::RESP_OKAY;
    localparam resp_e ERR = symb_rate_div_pkg::RESP_SLAVE_ERROR;
    localparam symb_rate_div_pkg::rate_sel_e FULL = symb_rate_div_pkg::RATE_FULL;
    localparam symb_rate_div_pkg::rate_sel_e HALF = symb_rate_div_pkg::RATE_HALF;
    localparam symb_rate_div_pkg::rate_sel_e QUAR = symb_rate_div_pkg::RATE_QUARTER;
    localparam logic [`SRD_DATA_W-1:0] ID_WORD = {`SRD_MODULE_ID, `SRD_MODULE_VERSION};

    logic                     rst_n_i;
    logic                     clk_ifc_avmm;
    logic [`SRD_ADDR_W-1:0]   avmm_address_i;
    logic                     avmm_write_i;
    logic                     avmm_read_i;
    logic [`SRD_DATA_W-1:0]   avmm_writedata_i;
    logic [`SRD_DATA_W-1:0]   avmm_readdata_o;
    logic                     avmm_readdatavalid_o;
    logic                     avmm_writeresponsevalid_o;
    resp_e                    avmm_response_o;
    logic                     avmm_waitrequest_o;
    symb_rate_div_pkg::beat_t in_beat_i;
    logic                     in_valid_i;
    logic                     in_ready_o;
    symb_rate_div_pkg::beat_t out_beat_o;
    logic                     out_valid_o;
    logic                     out_ready_i;

    symb_rate_div_pkg::sample_t cur_q[$];
    symb_rate_div_pkg::beat_t   exp_q[$];
    entry_t                     tbl[$];
    int                         value_errs  = 0;
    int                         proto_errs  = 0;
    int                         model_count = 0;
    int                         seen        = 0;
    logic [1:0]                 roll;

    symb_rate_div_top i_dut (.*);

    initial begin
        clk_ifc_avmm = 1'b0;
        forever #5 clk_ifc_avmm = ~clk_ifc_avmm;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_beat(input string name, input symb_rate_div_pkg::beat_t got, exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input resp_e got, exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED t=%0t %s got %s exp %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_word(input string name, input logic [`SRD_DATA_W-1:0] got, exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Floor of the mean per component
    function automatic symb_rate_div_pkg::sample_t average(
        input symb_rate_div_pkg::sample_t a,
        input symb_rate_div_pkg::sample_t b
    );
        symb_rate_div_pkg::sample_t m;
        int                         s_i;
        int                         s_q;
        s_i = int'(a.i) + int'(b.i);
        s_q = int'(a.q) + int'(b.q);
        m.i = `SRD_SAMPLE_W'(s_i >>> 1);
        m.q = `SRD_SAMPLE_W'(s_q >>> 1);
        return m;
    endfunction

    // One 2x pass over the whole frame in cur_q
    task automatic interpolate_once();
        symb_rate_div_pkg::sample_t src[$];
        src = cur_q;
        cur_q.delete();
        foreach (src[k]) begin
            cur_q.push_back(average((k == 0) ? src[0] : src[k-1], src[k]));
            cur_q.push_back(src[k]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers

    task automatic drive_reg(input logic [`SRD_ADDR_W-1:0] addr, input logic wr,
                             input logic [`SRD_DATA_W-1:0] data, input resp_e resp,
                             input logic [`SRD_DATA_W-1:0] rdata);
        @(negedge clk_ifc_avmm);
        while (avmm_waitrequest_o) @(negedge clk_ifc_avmm);
        avmm_address_i   = addr;
        avmm_writedata_i = data;
        avmm_write_i     = wr;
        avmm_read_i      = !wr;
        @(negedge clk_ifc_avmm);
        avmm_write_i = 1'b0;
        avmm_read_i  = 1'b0;
        if ((wr ? avmm_writeresponsevalid_o : avmm_readdatavalid_o) !== 1'b1) begin
            proto_errs++;
            $display("No response one cycle after the strobe to address %h at t=%0t",
                     addr, $time);
        end
        check_resp("avmm_response_o", avmm_response_o, resp);
        if (!wr) begin
            check_word("avmm_readdata_o", avmm_readdata_o, rdata);
        end
        @(negedge clk_ifc_avmm);
        if (avmm_readdatavalid_o || avmm_writeresponsevalid_o) begin
            proto_errs++;
            $display("Response valid lasted more than one cycle at t=%0t", $time);
        end
    endtask

    task automatic run_frame(input entry_t e);
        symb_rate_div_pkg::sample_t in_smp[$];
        symb_rate_div_pkg::beat_t   b;
        @(negedge clk_ifc_avmm);
        cur_q.delete();
        for (int k = 0; k < e.len; k++) begin
            b.sample = $urandom;
            cur_q.push_back(b.sample);
        end
        in_smp = cur_q;
        for (int s = 0; s < int'(e.rate); s++) begin
            interpolate_once();
        end
        foreach (cur_q[k]) begin
            b.sample = cur_q[k];
            b.last   = (k == cur_q.size() - 1);
            exp_q.push_back(b);
            model_count++;
        end
        for (int k = 0; k < e.len; k++) begin
            // Rate change lands after the frame has started
            if (e.mid_wr && k == e.len / 2) begin
                in_valid_i = 1'b0;
                drive_reg(`SRD_ADDR_W'(`SRD_REG_RATE * 4), 1'b1, e.data, OK, '0);
            end
            in_beat_i.sample = in_smp[k];
            in_beat_i.last   = (k == e.len - 1);
            in_valid_i       = 1'b1;
            @(posedge clk_ifc_avmm);
            while (!in_ready_o) @(posedge clk_ifc_avmm);
            @(negedge clk_ifc_avmm);
        end
        in_valid_i = 1'b0;
    endtask

    always @(posedge clk_ifc_avmm) begin
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                proto_errs++;
                $display("Output beat at t=%0t with no beat expected", $time);
            end else begin
                check_beat("out_beat_o", out_beat_o, exp_q.pop_front());
            end
            seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        time limit;
        rst_n_i          = 1'b0;
        avmm_address_i   = '0;
        avmm_write_i     = 1'b0;
        avmm_read_i      = 1'b0;
        avmm_writedata_i = '0;
        in_beat_i        = '0;
        in_valid_i       = 1'b0;
        out_ready_i      = 1'b0;
        void'($urandom(32'h63a3_ae24));

        tbl.push_back(entry_t'{1'b0, 4'h0, 1'b0, 32'h0, OK, ID_WORD, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b0, 32'h0, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h0, OK, 32'h0, FULL, 8'd8, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h1, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h0, OK, 32'h0, HALF, 8'd8, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h2, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h0, OK, 32'h0, QUAR, 8'd6, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h1, OK, 32'h0, FULL, 8'd0, 1'b0});
        // Quarter written mid-frame, the next frame follows back to back
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h2, OK, 32'h0, HALF, 8'd10, 1'b1});
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h0, OK, 32'h0, QUAR, 8'd12, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h0, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b1, 4'h0, 1'b0, 32'h0, OK, 32'h0, FULL, 8'd7, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h8, 1'b0, 32'h0, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h1, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b1, 32'h3, ERR, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b0, 32'h0, OK, 32'h1, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'hC, 1'b0, 32'h0, ERR, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'hC, 1'b1, 32'h2, ERR, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h0, 1'b1, 32'h7, OK, 32'h0, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h0, 1'b0, 32'h0, OK, ID_WORD, FULL, 8'd0, 1'b0});
        tbl.push_back(entry_t'{1'b0, 4'h4, 1'b0, 32'h0, OK, 32'h1, FULL, 8'd0, 1'b0});

        limit = 2000;
        foreach (tbl[n]) begin
            if (tbl[n].frame) begin
                limit += tbl[n].len * 8 * 10;
            end
        end
        fork
            begin
                #(limit);
                $display("Timeout after %0t, %0d expected beats never came out", $time,
                         exp_q.size());
                $display("** FAIL **");
                $finish;
            end
            // Random back-pressure, drawn on the rising edge and applied on the falling one
            forever begin
                @(posedge clk_ifc_avmm);
                roll = 2'($urandom);
                @(negedge clk_ifc_avmm);
                out_ready_i = roll != 2'd0;
            end
        join_none

        repeat (3) @(negedge clk_ifc_avmm);
        // Both ports idle while reset is held
        check_flag("avmm_waitrequest_o", avmm_waitrequest_o, 1'b1);
        check_flag("avmm_readdatavalid_o", avmm_readdatavalid_o, 1'b0);
        check_flag("avmm_writeresponsevalid_o", avmm_writeresponsevalid_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b0);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        rst_n_i = 1'b1;
        // Ports open on the first edge after release
        @(negedge clk_ifc_avmm);
        check_flag("avmm_waitrequest_o", avmm_waitrequest_o, 1'b0);
        check_flag("in_ready_o", in_ready_o, 1'b1);

        foreach (tbl[n]) begin
            if (tbl[n].frame) begin
                run_frame(tbl[n]);
            end else begin
                // Let the stream settle so COUNT is final
                while (exp_q.size() != 0) @(negedge clk_ifc_avmm);
                repeat (3) @(negedge clk_ifc_avmm);
                drive_reg(tbl[n].addr, tbl[n].wr, tbl[n].data, tbl[n].resp,
                          (tbl[n].addr[`SRD_ADDR_W-1:2] == `SRD_REG_COUNT)
                              ? `SRD_DATA_W'(model_count) : tbl[n].rdata);
            end
        end
        while (exp_q.size() != 0) @(negedge clk_ifc_avmm);
        repeat (3) @(negedge clk_ifc_avmm);

        $display("Done: %0d value errors, %0d protocol errors, %0d of %0d output beats seen",
                 value_errs, proto_errs, seen, model_count);
        if (value_errs == 0 && proto_errs == 0 && seen == model_count) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- symb_rate_div_top.sv
////////////////////////////////////////////////////////////////////////////
// Symbol-rate divider top, register block plus the interpolation chain
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

module symb_rate_div_top (
    input  logic                          rst_n_i,
    input  logic                          clk_ifc_avmm,
    input  logic [`SRD_ADDR_W-1:0]        avmm_address_i,
    input  logic                          avmm_write_i,
    input  logic [`SRD_DATA_W-1:0]        avmm_writedata_i,
    input  logic                          avmm_read_i,
    output logic [`SRD_DATA_W-1:0]        avmm_readdata_o,
    output logic                          avmm_readdatavalid_o,
    output logic                          avmm_writeresponsevalid_o,
    output symb_rate_div_pkg::avmm_resp_e avmm_response_o,
    output logic                          avmm_waitrequest_o,
    input  symb_rate_div_pkg::beat_t      in_beat_i,
    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    output symb_rate_div_pkg::beat_t      out_beat_o,
    output logic                          out_valid_o,
    input  logic                          out_ready_i
);

    symb_rate_div_pkg::rate_sel_e rate_sel;
    logic                         beat_done;

    // Index k is the input of stage k, the last index feeds the drain
    symb_rate_div_pkg::beat_t     beat_c  [0:`SRD_NUM_STAGES];
    logic                         valid_c [0:`SRD_NUM_STAGES];
    logic                         ready_c [0:`SRD_NUM_STAGES];
    logic [`SRD_NUM_STAGES-1:0]   en_c    [0:`SRD_NUM_STAGES];

    symb_rate_div_csr i_csr (
        .rst_n_i                   (rst_n_i),
        .clk_ifc_avmm              (clk_ifc_avmm),
        .avmm_address_i            (avmm_address_i),
        .avmm_write_i              (avmm_write_i),
        .avmm_writedata_i          (avmm_writedata_i),
        .avmm_read_i               (avmm_read_i),
        .avmm_readdata_o           (avmm_readdata_o),
        .avmm_readdatavalid_o      (avmm_readdatavalid_o),
        .avmm_writeresponsevalid_o (avmm_writeresponsevalid_o),
        .avmm_response_o           (avmm_response_o),
        .avmm_waitrequest_o        (avmm_waitrequest_o),
        .beat_done_i               (beat_done),
        .rate_sel_o                (rate_sel)
    );

    symb_rate_div_feed i_feed (
        .rst_n_i      (rst_n_i),
        .clk_ifc_avmm (clk_ifc_avmm),
        .in_beat_i    (in_beat_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .rate_sel_i   (rate_sel),
        .beat_o       (beat_c[0]),
        .valid_o      (valid_c[0]),
        .enable_o     (en_c[0]),
        .ready_i      (ready_c[0])
    );

    for (genvar k = 0; k < `SRD_NUM_STAGES; k++) begin : g_stage
        symb_rate_div_interp_stage #(
            .STAGE_IDX (k)
        ) i_stage (
            .rst_n_i      (rst_n_i),
            .clk_ifc_avmm (clk_ifc_avmm),
            .beat_i       (beat_c[k]),
            .valid_i      (valid_c[k]),
            .enable_i     (en_c[k]),
            .ready_o      (ready_c[k]),
            .beat_o       (beat_c[k+1]),
            .valid_o      (valid_c[k+1]),
            .enable_o     (en_c[k+1]),
            .ready_i      (ready_c[k+1])
        );
    end

    symb_rate_div_drain i_drain (
        .rst_n_i      (rst_n_i),
        .clk_ifc_avmm (clk_ifc_avmm),
        .beat_i       (beat_c[`SRD_NUM_STAGES]),
        .valid_i      (valid_c[`SRD_NUM_STAGES]),
        .ready_o      (ready_c[`SRD_NUM_STAGES]),
        .out_beat_o   (out_beat_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .beat_done_o  (beat_done)
    );

endmodule

//--- symb_rate_div_drain.sv
////////////////////////////////////////////////////////////////////////////
// Output skid buffer, reports every delivered beat to the register block
////////////////////////////////////////////////////////////////////////////

module symb_rate_div_drain (
    input  logic                     rst_n_i,
    input  logic                     clk_ifc_avmm,
    input  symb_rate_div_pkg::beat_t beat_i,
    input  logic                     valid_i,
    output logic                     ready_o,
    output symb_rate_div_pkg::beat_t out_beat_o,
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic                     beat_done_o
);

    symb_rate_div_pkg::beat_t skid_q;
    logic                     skid_valid_q;
    logic                     out_free;
    logic                     take;

    // Registered ready, the skid entry absorbs the beat in flight
    assign ready_o  = !skid_valid_q;
    assign out_free = !out_valid_o || out_ready_i;
    assign take     = valid_i && ready_o;

    always_ff @(posedge clk_ifc_avmm or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_o  <= 1'b0;
            skid_valid_q <= 1'b0;
            beat_done_o  <= 1'b0;
        end else begin
            beat_done_o <= out_valid_o && out_ready_i;
            if (out_free) begin
                out_valid_o  <= skid_valid_q || take;
                skid_valid_q <= 1'b0;
            end else if (take) begin
                skid_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (out_free) begin
            if (skid_valid_q) begin
                out_beat_o <= skid_q;
            end else if (take) begin
                out_beat_o <= beat_i;
            end
        end else if (take) begin
            skid_q <= beat_i;
        end
    end

endmodule

//--- symb_rate_div_interp_stage.sv
////////////////////////////////////////////////////////////////////////////
// One 2x linear interpolation stage, bypassed when its enable bit is low
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

module symb_rate_div_interp_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic                        rst_n_i,
    input  logic                        clk_ifc_avmm,
    input  symb_rate_div_pkg::beat_t    beat_i,
    input  logic                        valid_i,
    input  logic [`SRD_NUM_STAGES-1:0]  enable_i,
    output logic                        ready_o,
    output symb_rate_div_pkg::beat_t    beat_o,
    output logic                        valid_o,
    output logic [`SRD_NUM_STAGES-1:0]  enable_o,
    input  logic                        ready_i
);

    typedef enum logic {
        EMIT_MID,
        EMIT_ORIG
    } state_e;

    state_e                     state_q;
    logic                       first_q;
    logic                       load;
    logic                       take;
    logic                       en_self;
    symb_rate_div_pkg::sample_t prev_q;
    symb_rate_div_pkg::beat_t   hold_q;

    // Floor of the average, bits [W:1] of the sign-extended sum
    function automatic symb_rate_div_pkg::sample_t midpoint(
        input symb_rate_div_pkg::sample_t a,
        input symb_rate_div_pkg::sample_t b
    );
        symb_rate_div_pkg::sample_t m;
        logic [`SRD_SAMPLE_W:0]     sum_i;
        logic [`SRD_SAMPLE_W:0]     sum_q;
        sum_i = {a.i[`SRD_SAMPLE_W-1], a.i} + {b.i[`SRD_SAMPLE_W-1], b.i};
        sum_q = {a.q[`SRD_SAMPLE_W-1], a.q} + {b.q[`SRD_SAMPLE_W-1], b.q};
        m.i   = sum_i[`SRD_SAMPLE_W:1];
        m.q   = sum_q[`SRD_SAMPLE_W:1];
        return m;
    endfunction

    assign en_self = enable_i[STAGE_IDX];
    assign load    = !valid_o || ready_i;
    // No intake while the original sample is still pending
    assign ready_o = load && state_q == EMIT_MID;
    assign take    = valid_i && ready_o;

    ////////////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge clk_ifc_avmm or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMIT_MID;
            first_q <= 1'b1;
            valid_o <= 1'b0;
        end else if (load) begin
            if (state_q == EMIT_ORIG) begin
                valid_o <= 1'b1;
                state_q <= EMIT_MID;
            end else begin
                valid_o <= valid_i;
                if (valid_i) begin
                    first_q <= beat_i.last;
                    if (en_self) begin
                        state_q <= EMIT_ORIG;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath

    always_ff @(posedge clk_ifc_avmm) begin
        if (load && state_q == EMIT_ORIG) begin
            beat_o <= hold_q;
        end else if (take) begin
            enable_o <= enable_i;
            prev_q   <= beat_i.sample;
            hold_q   <= beat_i;
            if (en_self) begin
                // Frame start pairs the first sample with itself
                beat_o.sample <= midpoint(first_q ? beat_i.sample : prev_q, beat_i.sample);
                beat_o.last   <= 1'b0;
            end else begin
                beat_o <= beat_i;
            end
        end
    end

    a_hold_under_stall : assert property (
        @(posedge clk_ifc_avmm) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(beat_o)
    );

endmodule

//--- symb_rate_div_feed.sv
////////////////////////////////////////////////////////////////////////////
// Stream intake that picks up the rate at frame start and tags each beat
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

module symb_rate_div_feed (
    input  logic                            rst_n_i,
    input  logic                            clk_ifc_avmm,
    input  symb_rate_div_pkg::beat_t        in_beat_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  symb_rate_div_pkg::rate_sel_e    rate_sel_i,
    output symb_rate_div_pkg::beat_t        beat_o,
    output logic                            valid_o,
    output logic [`SRD_NUM_STAGES-1:0]      enable_o,
    input  logic                            ready_i
);

    symb_rate_div_pkg::rate_sel_e rate_q;
    symb_rate_div_pkg::rate_sel_e next_rate;
    logic                         run_q;
    logic                         first_q;
    logic                         load;
    logic                         take;

    // Half turns on stage 0, quarter turns on stages 0 and 1
    function automatic logic [`SRD_NUM_STAGES-1:0] stage_enables(
        input symb_rate_div_pkg::rate_sel_e rate
    );
        logic [`SRD_NUM_STAGES-1:0] en;
        for (int k = 0; k < `SRD_NUM_STAGES; k++) begin
            en[k] = k < int'(rate);
        end
        return en;
    endfunction

    assign load       = !valid_o || ready_i;
    assign in_ready_o = run_q && load;
    assign take       = in_valid_i && in_ready_o;
    assign next_rate  = first_q ? rate_sel_i : rate_q;

    always_ff @(posedge clk_ifc_avmm or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q   <= 1'b0;
            first_q <= 1'b1;
            valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (take) begin
                first_q <= in_beat_i.last;
            end
            if (load) begin
                valid_o <= take;
            end
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (take) begin
            beat_o   <= in_beat_i;
            rate_q   <= next_rate;
            enable_o <= stage_enables(next_rate);
        end
    end

    a_rate_not_reserved : assert property (
        @(posedge clk_ifc_avmm) disable iff (!rst_n_i)
        valid_o |-> rate_q != 2'd3
    );

endmodule

//--- symb_rate_div_csr.sv
////////////////////////////////////////////////////////////////////////////
// Register block with rate select, identifier word and output beat count
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

module symb_rate_div_csr (
    input  logic                          rst_n_i,
    input  logic                          clk_ifc_avmm,
    input  logic [`SRD_ADDR_W-1:0]        avmm_address_i,
    input  logic                          avmm_write_i,
    input  logic [`SRD_DATA_W-1:0]        avmm_writedata_i,
    input  logic                          avmm_read_i,
    output logic [`SRD_DATA_W-1:0]        avmm_readdata_o,
    output logic                          avmm_readdatavalid_o,
    output logic                          avmm_writeresponsevalid_o,
    output symb_rate_div_pkg::avmm_resp_e avmm_response_o,
    output logic                          avmm_waitrequest_o,
    input  logic                          beat_done_i,
    output symb_rate_div_pkg::rate_sel_e  rate_sel_o
);

    logic [`SRD_ADDR_W-3:0] word_addr;
    logic                   rd_stb;
    logic                   wr_stb;
    logic                   addr_bad;
    logic                   code_bad;
    logic [`SRD_DATA_W-1:0] count_q;

    // Byte address to word address
    assign word_addr = avmm_address_i[`SRD_ADDR_W-1:2];
    assign rd_stb    = avmm_read_i && !avmm_waitrequest_o;
    assign wr_stb    = avmm_write_i && !avmm_waitrequest_o;
    assign addr_bad  = word_addr >= `SRD_NUM_REGS;
    assign code_bad  = avmm_writedata_i[1:0] == 2'd3;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake, rate register and beat counter

    always_ff @(posedge clk_ifc_avmm or negedge rst_n_i) begin
        if (!rst_n_i) begin
            avmm_waitrequest_o        <= 1'b1;
            avmm_readdatavalid_o      <= 1'b0;
            avmm_writeresponsevalid_o <= 1'b0;
            rate_sel_o                <= symb_rate_div_pkg::RATE_FULL;
            count_q                   <= '0;
        end else begin
            avmm_waitrequest_o        <= 1'b0;
            avmm_readdatavalid_o      <= rd_stb;
            avmm_writeresponsevalid_o <= wr_stb;
            // Reserved code leaves the rate unchanged
            if (wr_stb && word_addr == `SRD_REG_RATE && !code_bad) begin
                rate_sel_o <= symb_rate_div_pkg::rate_sel_e'(avmm_writedata_i[1:0]);
            end
            if (beat_done_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read data and response

    always_ff @(posedge clk_ifc_avmm) begin
        if (rd_stb) begin
            avmm_response_o <= addr_bad ? symb_rate_div_pkg::RESP_SLAVE_ERROR
                                        : symb_rate_div_pkg::RESP_OKAY;
            case (word_addr)
                `SRD_REG_ID:    avmm_readdata_o <= {`SRD_MODULE_ID, `SRD_MODULE_VERSION};
                `SRD_REG_RATE:  avmm_readdata_o <= `SRD_DATA_W'(rate_sel_o);
                `SRD_REG_COUNT: avmm_readdata_o <= count_q;
                default:        avmm_readdata_o <= '0;
            endcase
        end else if (wr_stb) begin
            // ID and COUNT writes are dropped silently
            if (addr_bad || (word_addr == `SRD_REG_RATE && code_bad)) begin
                avmm_response_o <= symb_rate_div_pkg::RESP_SLAVE_ERROR;
            end else begin
                avmm_response_o <= symb_rate_div_pkg::RESP_OKAY;
            end
        end
    end

    a_no_rd_wr_overlap : assert property (
        @(posedge clk_ifc_avmm) disable iff (!rst_n_i)
        !(avmm_read_i && avmm_write_i)
    );

    a_one_valid_at_a_time : assert property (
        @(posedge clk_ifc_avmm) disable iff (!rst_n_i)
        !(avmm_readdatavalid_o && avmm_writeresponsevalid_o)
    );

endmodule

//--- symb_rate_div_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the symbol-rate divider, referenced by scoped names
////////////////////////////////////////////////////////////////////////////

`include "symb_rate_div_defines.svh"

package symb_rate_div_pkg;

    // One complex sample
    typedef struct packed {
        logic signed [`SRD_SAMPLE_W-1:0] i;
        logic signed [`SRD_SAMPLE_W-1:0] q;
    } sample_t;

    // Stream beat, last marks the final sample of a frame
    typedef struct packed {
        sample_t sample;
        logic    last;
    } beat_t;

    // Code 3 is reserved
    typedef enum logic [1:0] {
        RATE_FULL    = 2'd0,
        RATE_HALF    = 2'd1,
        RATE_QUARTER = 2'd2
    } rate_sel_e;

    typedef enum logic [1:0] {
        RESP_OKAY        = 2'd0,
        RESP_SLAVE_ERROR = 2'd2
    } avmm_resp_e;

endpackage

//--- symb_rate_div_defines.svh
////////////////////////////////////////////////////////////////////////////
// Widths, stage count and register map of the symbol-rate divider
// Include in every file that needs one of these constants
////////////////////////////////////////////////////////////////////////////

`ifndef SYMB_RATE_DIV_DEFINES_SVH
`define SYMB_RATE_DIV_DEFINES_SVH

// Sample and pipeline sizing
`define SRD_SAMPLE_W        16
`define SRD_NUM_STAGES      2

// Register port
`define SRD_ADDR_W          4
`define SRD_DATA_W          32

// Word addresses of the registers
`define SRD_REG_ID          0
`define SRD_REG_RATE        1
`define SRD_REG_COUNT       2
`define SRD_NUM_REGS        3

// Identifier word halves
`define SRD_MODULE_ID       16'h05D1
`define SRD_MODULE_VERSION  16'h0001

`endif
